// File: design/mem_map_pkg.sv
`default_nettype none

package mem_map_pkg;

	//////////////////////////////////////////////////
	// CPU address space
	//////////////////////////////////////////////////

	// four 16k windows over the 64k Z80 space
	localparam int NUM_WINDOWS = 4;

	typedef logic [1:0]  win_idx_t;
	typedef logic [5:0]  page_t;
	typedef logic [15:0] zaddr_t;
	typedef logic [13:0] offset_t;

	// fixed Pentagon RAM pages in windows 1 and 2
	localparam page_t RAM_PAGE_W1 = page_t'(5);
	localparam page_t RAM_PAGE_W2 = page_t'(2);

	// high byte of the TR-DOS entry area
	localparam logic [7:0] DOS_ENTRY_HI = 8'h3D;

	//////////////////////////////////////////////////
	// mapping structs
	//////////////////////////////////////////////////

	// what one window currently points at
	typedef struct packed {
		logic  is_ram;
		page_t page;
	} win_map_t;

	// memory access as seen from the Z80 side
	typedef struct packed {
		zaddr_t addr;
		logic   m1;
	} mem_req_t;

	typedef struct packed {
		logic    is_ram;
		page_t   page;
		offset_t offset;
	} map_res_t;

endpackage

`default_nettype wire

// File: design/io_port_pkg.sv
`default_nettype none

package io_port_pkg;

	typedef logic [15:0] io_addr_t;
	typedef logic [7:0]  io_data_t;

	// one Z80 OUT cycle
	typedef struct packed {
		io_addr_t addr;
		io_data_t data;
	} io_wr_t;

	//////////////////////////////////////////////////
	// paging port addresses
	//////////////////////////////////////////////////

	localparam io_addr_t    P7FFD_ADDR     = 16'h7FFD;
	localparam logic [7:0]  PAGER_EN_LOW   = 8'h77;
	localparam logic [11:0] ATM_PAGE_LOW12 = 12'hFF7;

	// data bit positions
	localparam int P7FFD_ROM_BIT = 4;
	localparam int P7FFD_LOCK_BIT = 5;
	localparam int PAGER_EN_BIT = 0;
	localparam int ATM_RAM_BIT = 7;

	// #7FFD state plus the ATM pager enable from #xx77
	typedef struct packed {
		logic [2:0] ram_page;
		logic       rom_sel;
		logic       lock;
		logic       pager_en;
	} pent_cfg_t;

endpackage

`default_nettype wire

// File: design/page_port_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module page_port_decoder
	import mem_map_pkg::*;
	import io_port_pkg::*;
(
	input  logic                   fclk,
	input  logic                   arst_n,

	// Z80 I/O write
	input  logic                   io_wr_stb,
	input  io_wr_t                 io_wr,

	// paging state
	output pent_cfg_t              cfg,

	// per-window ATM page writes
	output logic [NUM_WINDOWS-1:0] atm_wr,
	output io_data_t               atm_data
);

	logic     hit_7ffd;
	logic     hit_77;
	logic     hit_ff7;
	win_idx_t wr_win;

	//////////////////////////////////////////////////
	// port address decode
	//////////////////////////////////////////////////

	// #7FFD is decoded on the full address
	assign hit_7ffd = io_wr_stb && (io_wr.addr == P7FFD_ADDR);

	// #xx77 only looks at the low byte
	assign hit_77 = io_wr_stb && (io_wr.addr[7:0] == PAGER_EN_LOW);

	// #xFF7, window taken from the top address bits
	assign hit_ff7 = io_wr_stb && (io_wr.addr[11:0] == ATM_PAGE_LOW12);

	assign wr_win = io_wr.addr[15:14];

	//////////////////////////////////////////////////
	// ATM page write strobes
	//////////////////////////////////////////////////

	always_comb
	begin
		atm_wr = '0;
		if (hit_ff7)
		begin
			atm_wr[wr_win] = 1'b1;
		end
	end

	// pagers pick the fields they need
	assign atm_data = io_wr.data;

	//////////////////////////////////////////////////
	// configuration registers
	//////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cfg <= '0;
		end
		else
		begin
			// locked until the next reset
			if (hit_7ffd && !cfg.lock)
			begin
				cfg.ram_page <= io_wr.data[2:0];
				cfg.rom_sel  <= io_wr.data[P7FFD_ROM_BIT];
				cfg.lock     <= io_wr.data[P7FFD_LOCK_BIT];
			end

			if (hit_77)
			begin
				cfg.pager_en <= io_wr.data[PAGER_EN_BIT];
			end
		end
	end

endmodule

`default_nettype wire

// File: design/atm_pager.sv
`timescale 1ns/1ps
`default_nettype none

module atm_pager
	import mem_map_pkg::*;
	import io_port_pkg::*;
#(
	// window position, 0 to 3
	parameter int WINDOW = 0
)(
	input  logic      fclk,
	input  logic      arst_n,

	// page write for this window
	input  logic      atm_wr,
	input  io_data_t  atm_data,

	input  pent_cfg_t cfg,
	input  logic      dos,

	output win_map_t  win_map
);

	// one bank per rom_sel value
	win_map_t [1:0] bank;
	win_map_t       pent_map;

	//////////////////////////////////////////////////
	// ATM page registers
	//////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			// ROM page 0 in both banks
			bank <= '0;
		end
		else if (atm_wr)
		begin
			bank[cfg.rom_sel].is_ram <= atm_data[ATM_RAM_BIT];
			bank[cfg.rom_sel].page   <= atm_data[5:0];
		end
	end

	//////////////////////////////////////////////////
	// Pentagon fallback map
	//////////////////////////////////////////////////

	always_comb
	begin
		case (win_idx_t'(WINDOW))
			2'd0:
			begin
				// basic/128 ROM, TR-DOS pages above
				pent_map.is_ram = 1'b0;
				pent_map.page   = page_t'({dos, cfg.rom_sel});
			end
			2'd1:
			begin
				pent_map.is_ram = 1'b1;
				pent_map.page   = RAM_PAGE_W1;
			end
			2'd2:
			begin
				pent_map.is_ram = 1'b1;
				pent_map.page   = RAM_PAGE_W2;
			end
			default:
			begin
				// window 3 follows #7FFD
				pent_map.is_ram = 1'b1;
				pent_map.page   = page_t'(cfg.ram_page);
			end
		endcase
	end

	// ATM banks take over once the pager is enabled
	always_comb
	begin
		if (cfg.pager_en)
		begin
			win_map = bank[cfg.rom_sel];
		end
		else
		begin
			win_map = pent_map;
		end
	end

endmodule

`default_nettype wire

// File: design/addr_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module addr_mapper
	import mem_map_pkg::*;
	import io_port_pkg::*;
(
	input  logic                       fclk,
	input  logic                       arst_n,

	// CPU memory access
	input  logic                       mem_req_stb,
	input  mem_req_t                   mem_req,

	// current window maps from the pagers
	input  win_map_t [NUM_WINDOWS-1:0] win_maps,
	input  pent_cfg_t                  cfg,

	output logic                       map_valid,
	output map_res_t                   map_res,
	output logic                       dos
);

	win_idx_t req_win;
	win_map_t sel_map;
	logic     fetch;
	logic     dos_on;
	logic     dos_off;

	//////////////////////////////////////////////////
	// window select
	//////////////////////////////////////////////////

	assign req_win = mem_req.addr[15:14];
	assign sel_map = win_maps[req_win];

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			map_valid <= 1'b0;
		end
		else
		begin
			map_valid <= mem_req_stb;
		end
	end

	// result only meaningful with map_valid
	always_ff @(posedge fclk)
	begin
		if (mem_req_stb)
		begin
			map_res.is_ram <= sel_map.is_ram;
			map_res.page   <= sel_map.page;
			map_res.offset <= mem_req.addr[13:0];
		end
	end

	//////////////////////////////////////////////////
	// TR-DOS flag
	//////////////////////////////////////////////////

	assign fetch = mem_req_stb && mem_req.m1;

	// entry needs the 48k basic ROM in window 0
	assign dos_on = fetch
		&& (mem_req.addr[15:8] == DOS_ENTRY_HI)
		&& !win_maps[0].is_ram
		&& cfg.rom_sel;

	// any fetch from #4000 up leaves TR-DOS
	assign dos_off = fetch && (req_win != '0);

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			dos <= 1'b0;
		end
		else if (dos_on)
		begin
			dos <= 1'b1;
		end
		else if (dos_off)
		begin
			dos <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: design/mem_pager_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_pager_top
	import mem_map_pkg::*;
	import io_port_pkg::*;
(
	input  logic     fclk,
	input  logic     arst_n,

	// Z80 I/O writes
	input  logic     io_wr_stb,
	input  io_wr_t   io_wr,

	// Z80 memory accesses
	input  logic     mem_req_stb,
	input  mem_req_t mem_req,

	output logic     map_valid,
	output map_res_t map_res
);

	pent_cfg_t                  cfg;
	logic [NUM_WINDOWS-1:0]     atm_wr;
	io_data_t                   atm_data;
	win_map_t [NUM_WINDOWS-1:0] win_maps;
	logic                       dos;

	page_port_decoder page_port_decoder_i (
		.fclk      (fclk),
		.arst_n    (arst_n),
		.io_wr_stb (io_wr_stb),
		.io_wr     (io_wr),
		.cfg       (cfg),
		.atm_wr    (atm_wr),
		.atm_data  (atm_data)
	);

	//////////////////////////////////////////////////
	// one pager per 16k window
	//////////////////////////////////////////////////

	for (genvar w = 0; w < NUM_WINDOWS; w++)
	begin : g_pager
		atm_pager #(
			.WINDOW (w)
		) atm_pager_i (
			.fclk     (fclk),
			.arst_n   (arst_n),
			.atm_wr   (atm_wr[w]),
			.atm_data (atm_data),
			.cfg      (cfg),
			.dos      (dos),
			.win_map  (win_maps[w])
		);
	end

	addr_mapper addr_mapper_i (
		.fclk        (fclk),
		.arst_n      (arst_n),
		.mem_req_stb (mem_req_stb),
		.mem_req     (mem_req),
		.win_maps    (win_maps),
		.cfg         (cfg),
		.map_valid   (map_valid),
		.map_res     (map_res),
		.dos         (dos)
	);

endmodule

`default_nettype wire

// File: dv/mem_pager_chk.sv
`timescale 1ns/1ps
`default_nettype none

module mem_pager_chk
	import mem_map_pkg::*;
(
	input logic     fclk,
	input logic     arst_n,
	input logic     mem_req_stb,
	input mem_req_t mem_req,
	input logic     map_valid,
	input logic     dos
);

	// results only for the request one cycle earlier
	a_valid_after_req: assert property (@(posedge fclk) disable iff (!arst_n)
		map_valid |-> $past(mem_req_stb))
		else $error("map_valid without a request in the previous cycle");

	a_req_gets_valid: assert property (@(posedge fclk) disable iff (!arst_n)
		mem_req_stb |=> map_valid)
		else $error("request not answered in the next cycle");

	a_valid_in_reset: assert property (@(posedge fclk) !arst_n |-> !map_valid)
		else $error("map_valid high during reset");

	// TR-DOS entered only from a fetch at #3Dxx
	a_dos_entry: assert property (@(posedge fclk) disable iff (!arst_n)
		$rose(dos) |-> $past(mem_req_stb && mem_req.m1 && mem_req.addr[15:8] == DOS_ENTRY_HI))
		else $error("dos rose without a fetch from the entry page");

endmodule

bind addr_mapper mem_pager_chk mem_pager_chk_i (
	.fclk        (fclk),
	.arst_n      (arst_n),
	.mem_req_stb (mem_req_stb),
	.mem_req     (mem_req),
	.map_valid   (map_valid),
	.dos         (dos)
);

`default_nettype wire

// File: dv/tb_mem_pager.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_pager
	import mem_map_pkg::*;
	import io_port_pkg::*;
();

	localparam int DRAIN_TIMEOUT = 40;

	logic     fclk;
	logic     arst_n;
	logic     io_wr_stb;
	io_wr_t   io_wr;
	logic     mem_req_stb;
	mem_req_t mem_req;
	logic     map_valid;
	map_res_t map_res;

	// reference model of the paging state
	pent_cfg_t m_cfg;
	win_map_t  m_bank [NUM_WINDOWS][2];
	logic      m_dos;

	// expected results and the cycle each one is due in
	map_res_t exp_q [$];
	int       due_q [$];
	int       cyc = 0;
	int       seed = 32'hb6a9;

	mem_pager_top mem_pager_top_i (.*);

	initial
	begin
		fclk = 1'b0;
		forever #4 fclk = ~fclk;
	end

	always @(posedge fclk)
		cyc <= cyc + 1;

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	function automatic win_map_t window_map(input win_idx_t w);
		if (m_cfg.pager_en)
			return m_bank[w][m_cfg.rom_sel];
		case (w)
			2'd0: return {1'b0, page_t'(2 * m_dos + m_cfg.rom_sel)};
			2'd1: return {1'b1, page_t'(5)};
			2'd2: return {1'b1, page_t'(2)};
			default: return {1'b1, page_t'(m_cfg.ram_page)};
		endcase
	endfunction

	function automatic map_res_t expected_map(input mem_req_t req);
		win_map_t wm;
		wm = window_map(req.addr[15:14]);
		return {wm.is_ram, wm.page, req.addr[13:0]};
	endfunction

	task automatic check_val(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		if (actual !== expected)
		begin
			$display("FAIL @ %0t ns: %s, got %0h, expected %0h", $time, msg, actual, expected);
			$display("TEST FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s at %0t ns", why, $time);
		$display("TEST FAIL");
		$fatal(1, "run aborted");
	endtask

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	// one cycle of bus activity, model sees the state before the edge
	task automatic drive_cycle(input logic io_en, input io_wr_t io, input logic req_en,
		input mem_req_t req);
		logic     dos_next;
		win_map_t w0;
		io_wr_stb   = io_en;
		io_wr       = io;
		mem_req_stb = req_en;
		mem_req     = req;
		dos_next    = m_dos;
		w0          = window_map(2'd0);
		if (req_en)
		begin
			exp_q.push_back(expected_map(req));
			due_q.push_back(cyc + 1);
			if (req.m1 && req.addr[15:8] == 8'h3D && !w0.is_ram && m_cfg.rom_sel)
				dos_next = 1'b1;
			else if (req.m1 && req.addr >= 16'h4000)
				dos_next = 1'b0;
		end
		// bank write uses rom_sel before a same-cycle #7FFD update
		if (io_en && io.addr[11:0] == 12'hFF7)
			m_bank[io.addr[15:14]][m_cfg.rom_sel] = {io.data[7], io.data[5:0]};
		if (io_en && io.addr == 16'h7FFD && !m_cfg.lock)
			m_cfg[5:1] = {io.data[2:0], io.data[4], io.data[5]};
		if (io_en && io.addr[7:0] == 8'h77)
			m_cfg.pager_en = io.data[0];
		m_dos = dos_next;
		@(posedge fclk);
		#1;
		io_wr_stb   = 1'b0;
		mem_req_stb = 1'b0;
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		drive_cycle(1'b1, {addr, data}, 1'b0, '0);
	endtask

	task automatic mem_read(input logic [15:0] addr, input logic m1);
		drive_cycle(1'b0, '0, 1'b1, {addr, m1});
	endtask

	// back to back reads, one per window
	task automatic read_windows(input logic [13:0] offset);
		for (int w = 0; w < NUM_WINDOWS; w++)
			mem_read({w[1:0], offset}, 1'b0);
	endtask

	task automatic random_cycle();
		logic [31:0] r_io;
		logic [31:0] r_req;
		io_wr_t      io;
		mem_req_t    req;
		r_io  = $random(seed);
		r_req = $random(seed);
		io    = {r_io[31:16], r_io[7:0]};
		case (r_io[9:8])
			2'd0: io.addr = 16'h7FFD;
			2'd1: io.addr[7:0] = 8'h77;
			2'd2: io.addr[11:0] = 12'hFF7;
			default: ;
		endcase
		// rare lock so paging keeps moving
		io.data[5] = io.data[5] && (r_io[14:10] == 5'd0);
		req = {r_req[15:0], r_req[16]};
		if (r_req[17] && r_req[18])
			req.addr[15:8] = 8'h3D;
		drive_cycle(r_io[15:12] < 4'd5, io, r_req[19] || r_req[20], req);
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0)
		begin
			@(posedge fclk);
			#1;
			n++;
			if (n > DRAIN_TIMEOUT)
				abort_run("timeout waiting for map_valid");
		end
	endtask

	task automatic apply_reset();
		wait_drain();
		arst_n = 1'b0;
		m_cfg  = '0;
		m_dos  = 1'b0;
		for (int w = 0; w < NUM_WINDOWS; w++)
			m_bank[w] = '{2{win_map_t'(0)}};
		repeat (8) @(posedge fclk);
		#1;
		arst_n = 1'b1;
	endtask

	//////////////////////////////////////////////////
	// compare
	//////////////////////////////////////////////////

	always @(negedge fclk)
	begin
		if (arst_n && map_valid)
		begin
			if (exp_q.size() == 0)
				abort_run("map_valid seen with no request outstanding");
			else
			begin
				check_val(map_res, exp_q.pop_front(), "map result");
				check_val(cyc, due_q.pop_front(), "result cycle");
			end
		end
	end

	initial
	begin
		arst_n      = 1'b1;
		io_wr_stb   = 1'b0;
		io_wr       = '0;
		mem_req_stb = 1'b0;
		mem_req     = '0;
		#1;
		apply_reset();
		read_windows(14'h0123);
		read_windows(14'h3FFF);

		// #7FFD pages, then lock
		io_write(16'h7FFD, 8'h13);
		read_windows(14'h0040);
		io_write(16'h7FFD, 8'h07);
		read_windows(14'h1000);
		io_write(16'h7FFD, 8'h34);
		io_write(16'h7FFD, 8'h12);
		read_windows(14'h2222);

		// ATM banks per rom_sel
		apply_reset();
		io_write(16'h0077, 8'h01);
		for (int w = 0; w < NUM_WINDOWS; w++)
			io_write({w[1:0], 14'h0FF7}, 8'h80 + w * 9 + 3);
		read_windows(14'h0555);
		io_write(16'h7FFD, 8'h10);
		read_windows(14'h0555);
		// odd windows RAM in bank 1
		for (int w = 0; w < NUM_WINDOWS; w++)
			io_write({w[1:0], 14'h3FF7}, 8'h20 + w + (w % 2) * 8'h80);
		read_windows(14'h0AAA);
		io_write(16'h7FFD, 8'h00);
		read_windows(14'h0AAA);
		io_write(16'h1277, 8'h00);
		read_windows(14'h0AAA);

		// TR-DOS entry and exit
		apply_reset();
		io_write(16'h7FFD, 8'h10);
		mem_read(16'h3D2F, 1'b1);
		mem_read(16'h0100, 1'b0);
		mem_read(16'hC000, 1'b0);
		mem_read(16'h0200, 1'b0);
		mem_read(16'h8000, 1'b1);
		mem_read(16'h3D00, 1'b0);
		mem_read(16'h0100, 1'b0);

		apply_reset();
		for (int i = 0; i < 600; i++)
			random_cycle();
		wait_drain();
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
design/mem_map_pkg.sv
design/io_port_pkg.sv
design/page_port_decoder.sv
design/atm_pager.sv
design/addr_mapper.sv
design/mem_pager_top.sv
dv/mem_pager_chk.sv
dv/tb_mem_pager.sv

// File: Bender.yml
package:
  name: mem_pager

sources:
  # packages first, then RTL bottom up
  - files:
      - design/mem_map_pkg.sv
      - design/io_port_pkg.sv
      - design/page_port_decoder.sv
      - design/atm_pager.sv
      - design/addr_mapper.sv
      - design/mem_pager_top.sv

  - target: simulation
    files:
      - dv/mem_pager_chk.sv
      - dv/tb_mem_pager.sv
